/* common/icache_ctrl_pkg.sv */
////////////////////////////////////////////////////////////////////////////
// Instruction cache control unit shared definitions
// Core count, bus widths, register map and readback fill values
////////////////////////////////////////////////////////////////////////////

`default_nettype none

package icache_ctrl_pkg;

    // Number of cores with a private instruction cache
    localparam int NB_CORES = 4;

    // Bus and counter width
    localparam int DATA_W = 32;

    // Transaction id width on the register bus
    localparam int ID_W = 5;

    // Decoded register address bits
    localparam int ADDR_W = 8;

    typedef logic [DATA_W-1:0]   word_t;
    typedef logic [NB_CORES-1:0] core_vec_t;
    typedef logic [ADDR_W-1:0]   reg_addr_t;
    typedef logic [ID_W-1:0]     txn_id_t;

    // Register map, byte offsets
    localparam reg_addr_t REG_ENABLE     = 8'h00;
    localparam reg_addr_t REG_FLUSH      = 8'h04;
    localparam reg_addr_t REG_RSVD       = 8'h08;
    localparam reg_addr_t REG_CLEAR_CNT  = 8'h0C;
    localparam reg_addr_t REG_ENABLE_CNT = 8'h10;
    localparam reg_addr_t REG_HIT_SUM    = 8'h14;
    localparam reg_addr_t REG_TRANS_SUM  = 8'h18;
    localparam reg_addr_t REG_MISS_SUM   = 8'h1C;

    // Readback patterns for the reserved slot and unmapped offsets
    localparam word_t RSVD_VALUE     = 32'hBADD_A555;
    localparam word_t UNMAPPED_VALUE = 32'hDEAD_A555;

endpackage

`default_nettype wire

/* common/cfg_access_if.sv */
////////////////////////////////////////////////////////////////////////////
// Register access path from the control FSM to the register block
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

interface cfg_access_if;

    import icache_ctrl_pkg::*;

    // Single cycle strobes, valid in the bus acceptance cycle
    logic      wr_en;
    logic      rd_en;
    reg_addr_t addr;
    word_t     wdata;

    // Sequencing requests from the FSM
    logic      clear_pulse;
    logic      flush_done;

    modport fsm (output wr_en, rd_en, addr, wdata, clear_pulse, flush_done);

    modport regs (input wr_en, rd_en, addr, wdata, clear_pulse, flush_done);

endinterface

`default_nettype wire

/* common/ack_track_if.sv */
////////////////////////////////////////////////////////////////////////////
// Handshake between the control FSM and the acknowledge tracker
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

interface ack_track_if;

    // Collection windows and reset of the sticky bits
    logic listen_bypass;
    logic listen_flush;
    logic clear;

    // All cores settled
    logic bypass_done;
    logic flush_done_all;

    modport fsm (output listen_bypass, listen_flush, clear,
                 input bypass_done, flush_done_all);

    modport tracker (input listen_bypass, listen_flush, clear,
                     output bypass_done, flush_done_all);

endinterface

`default_nettype wire

/* hw/icache_ctrl/icache_ack_tracker.sv */
////////////////////////////////////////////////////////////////////////////
// Acknowledge tracker for per-core bypass and flush commands
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module icache_ack_tracker (
    input  wire logic                       clk_i,
    input  wire logic                       rst_ni,
    input  wire icache_ctrl_pkg::core_vec_t bypass_req_i,
    input  wire icache_ctrl_pkg::core_vec_t bypass_ack_i,
    input  wire icache_ctrl_pkg::core_vec_t flush_req_i,
    input  wire icache_ctrl_pkg::core_vec_t flush_ack_i,
    ack_track_if.tracker                    ack
);

    import icache_ctrl_pkg::*;

    core_vec_t bypass_settled;
    core_vec_t flush_settled;
    core_vec_t bypass_seen_q;
    core_vec_t flush_seen_q;

    // A core has settled once its acknowledge follows its request
    assign bypass_settled = ~(bypass_req_i ^ bypass_ack_i);

    // Cores without a flush request have nothing to acknowledge
    assign flush_settled = ~flush_req_i | flush_ack_i;

    always_ff @(posedge clk_i or negedge rst_ni)
    begin
        if (!rst_ni)
        begin
            bypass_seen_q <= '0;
            flush_seen_q  <= '0;
        end
        else if (ack.clear)
        begin
            bypass_seen_q <= '0;
            flush_seen_q  <= '0;
        end
        else
        begin
            if (ack.listen_bypass)
                bypass_seen_q <= bypass_seen_q | bypass_settled;
            if (ack.listen_flush)
                flush_seen_q <= flush_seen_q | (flush_req_i & flush_ack_i);
        end
    end

    // Current cycle counts too, so done can rise in the first wait cycle
    assign ack.bypass_done    = &(bypass_seen_q | bypass_settled);
    assign ack.flush_done_all = &(flush_seen_q | flush_settled);

    a_listen_exclusive: assert property (@(posedge clk_i) disable iff (!rst_ni)
        !(ack.listen_bypass && ack.listen_flush));

endmodule

`default_nettype wire

/* hw/icache_ctrl/icache_ctrl_fsm.sv */
////////////////////////////////////////////////////////////////////////////
// Control FSM of the instruction cache control unit
// Grants bus requests, sequences commands and returns responses
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module icache_ctrl_fsm (
    input  wire logic                       clk_i,
    input  wire logic                       rst_ni,
    input  wire logic                       req_i,
    input  wire icache_ctrl_pkg::reg_addr_t addr_i,
    input  wire logic                       wen_i,
    input  wire icache_ctrl_pkg::word_t     wdata_i,
    input  wire icache_ctrl_pkg::txn_id_t   id_i,
    output logic                            gnt_o,
    output logic                            r_valid_o,
    output icache_ctrl_pkg::txn_id_t        r_id_o,
    cfg_access_if.fsm                       cfg,
    ack_track_if.fsm                        ack
);

    import icache_ctrl_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        BYPASS_WAIT,
        FLUSH_WAIT,
        STAT_UPDATE
    } state_e;

    state_e  state_q;
    state_e  state_d;
    logic    accept;
    logic    resp_d;
    logic    r_valid_q;
    logic    is_clear_q;
    txn_id_t r_id_q;

    // Grant only while idle, wen_i high selects a read
    assign gnt_o  = (state_q == IDLE);
    assign accept = req_i && gnt_o;

    assign cfg.rd_en = accept && wen_i;
    assign cfg.wr_en = accept && !wen_i;
    assign cfg.addr  = addr_i;
    assign cfg.wdata = wdata_i;

    // Clear pulse only for a write to the clear-counter register
    assign cfg.clear_pulse = (state_q == STAT_UPDATE) && is_clear_q;

    assign ack.listen_bypass = (state_q == BYPASS_WAIT);
    assign ack.listen_flush  = (state_q == FLUSH_WAIT);

    // Flush register drops at the edge that raises the response
    assign cfg.flush_done = ack.listen_flush && ack.flush_done_all;

    always_comb
    begin
        state_d   = state_q;
        resp_d    = 1'b0;
        ack.clear = 1'b0;
        case (state_q)
            IDLE:
            begin
                if (cfg.rd_en)
                begin
                    resp_d = 1'b1;
                end
                else if (cfg.wr_en)
                begin
                    case (addr_i)
                        REG_ENABLE:     state_d = BYPASS_WAIT;
                        REG_FLUSH:      state_d = FLUSH_WAIT;
                        REG_CLEAR_CNT,
                        REG_ENABLE_CNT: state_d = STAT_UPDATE;
                        // Unmapped or read-only offset, answer right away
                        default:        resp_d  = 1'b1;
                    endcase
                end
            end
            BYPASS_WAIT:
            begin
                if (ack.bypass_done)
                begin
                    state_d   = IDLE;
                    resp_d    = 1'b1;
                    ack.clear = 1'b1;
                end
            end
            FLUSH_WAIT:
            begin
                if (ack.flush_done_all)
                begin
                    state_d   = IDLE;
                    resp_d    = 1'b1;
                    ack.clear = 1'b1;
                end
            end
            default:
            begin
                state_d = IDLE;
                resp_d  = 1'b1;
            end
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni)
    begin
        if (!rst_ni)
        begin
            state_q    <= IDLE;
            r_valid_q  <= 1'b0;
            is_clear_q <= 1'b0;
        end
        else
        begin
            state_q   <= state_d;
            r_valid_q <= resp_d;
            if (cfg.wr_en)
            begin
                is_clear_q <= (addr_i == REG_CLEAR_CNT);
            end
        end
    end

    // Id of the accepted request, held until its response
    always_ff @(posedge clk_i)
    begin
        if (accept)
        begin
            r_id_q <= id_i;
        end
    end

    assign r_valid_o = r_valid_q;
    assign r_id_o    = r_id_q;

    // Grant stays low through a wait and comes back with its response
    a_gnt_held_until_resp: assert property (@(posedge clk_i) disable iff (!rst_ni)
        !gnt_o |=> (gnt_o == r_valid_o));

    a_resp_single: assert property (@(posedge clk_i) disable iff (!rst_ni)
        r_valid_o |=> !r_valid_o);

endmodule

`default_nettype wire

/* hw/icache_ctrl/icache_ctrl_regs.sv */
////////////////////////////////////////////////////////////////////////////
// Control registers of the instruction cache control unit
// Holds enable, flush and statistics controls, sums counters, reads back
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module icache_ctrl_regs (
    input  wire logic                   clk_i,
    input  wire logic                   rst_ni,
    cfg_access_if.regs                  cfg,
    input  wire icache_ctrl_pkg::word_t hit_count_i   [icache_ctrl_pkg::NB_CORES],
    input  wire icache_ctrl_pkg::word_t trans_count_i [icache_ctrl_pkg::NB_CORES],
    input  wire icache_ctrl_pkg::word_t miss_count_i  [icache_ctrl_pkg::NB_CORES],
    output icache_ctrl_pkg::core_vec_t  bypass_req_o,
    output icache_ctrl_pkg::core_vec_t  flush_req_o,
    output icache_ctrl_pkg::core_vec_t  clear_stat_o,
    output icache_ctrl_pkg::core_vec_t  enable_stat_o,
    output icache_ctrl_pkg::word_t      r_rdata_o
);

    import icache_ctrl_pkg::*;

    core_vec_t enable_q;
    core_vec_t flush_q;
    core_vec_t clear_q;
    core_vec_t enable_cnt_q;

    word_t hit_sum;
    word_t trans_sum;
    word_t miss_sum;
    word_t rd_mux;
    word_t rdata_q;

    // Register writes, the flush mask clears itself once all cores are done
    always_ff @(posedge clk_i or negedge rst_ni)
    begin
        if (!rst_ni)
        begin
            enable_q     <= '0;
            flush_q      <= '0;
            clear_q      <= '0;
            enable_cnt_q <= '0;
        end
        else
        begin
            if (cfg.flush_done)
            begin
                flush_q <= '0;
            end
            if (cfg.wr_en)
            begin
                case (cfg.addr)
                    REG_ENABLE:     enable_q     <= cfg.wdata[NB_CORES-1:0];
                    REG_FLUSH:      flush_q      <= cfg.wdata[NB_CORES-1:0];
                    REG_CLEAR_CNT:  clear_q      <= cfg.wdata[NB_CORES-1:0];
                    REG_ENABLE_CNT: enable_cnt_q <= cfg.wdata[NB_CORES-1:0];
                    default:        ;
                endcase
            end
        end
    end

    // An enabled cache is not bypassed
    assign bypass_req_o  = ~enable_q;
    assign flush_req_o   = flush_q;
    assign enable_stat_o = enable_cnt_q;
    assign clear_stat_o  = cfg.clear_pulse ? clear_q : '0;

    // Global statistics, wrapping modulo 2^DATA_W
    always_comb
    begin
        hit_sum   = '0;
        trans_sum = '0;
        miss_sum  = '0;
        for (int i = 0; i < NB_CORES; i++)
        begin
            hit_sum   = hit_sum + hit_count_i[i];
            trans_sum = trans_sum + trans_count_i[i];
            miss_sum  = miss_sum + miss_count_i[i];
        end
    end

    always_comb
    begin
        case (cfg.addr)
            REG_ENABLE:     rd_mux = word_t'(enable_q);
            REG_FLUSH:      rd_mux = word_t'(flush_q);
            REG_RSVD:       rd_mux = RSVD_VALUE;
            REG_CLEAR_CNT:  rd_mux = word_t'(clear_q);
            REG_ENABLE_CNT: rd_mux = word_t'(enable_cnt_q);
            REG_HIT_SUM:    rd_mux = hit_sum;
            REG_TRANS_SUM:  rd_mux = trans_sum;
            REG_MISS_SUM:   rd_mux = miss_sum;
            default:        rd_mux = UNMAPPED_VALUE;
        endcase
    end

    // Read data lines up with the response valid, zero otherwise
    always_ff @(posedge clk_i)
    begin
        rdata_q <= cfg.rd_en ? rd_mux : '0;
    end

    assign r_rdata_o = rdata_q;

    a_clear_single: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (|clear_stat_o) |=> !(|clear_stat_o));

endmodule

`default_nettype wire

/* hw/icache_ctrl/icache_ctrl_top.sv */
////////////////////////////////////////////////////////////////////////////
// Instruction cache control unit
// Register bus slave that enables, bypasses and flushes per-core caches
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module icache_ctrl_top (
    input  wire logic                       clk_i,
    input  wire logic                       rst_ni,

    // Register bus
    input  wire logic                       req_i,
    input  wire icache_ctrl_pkg::reg_addr_t addr_i,
    input  wire logic                       wen_i,
    input  wire icache_ctrl_pkg::word_t     wdata_i,
    input  wire icache_ctrl_pkg::txn_id_t   id_i,
    output logic                            gnt_o,
    output logic                            r_valid_o,
    output icache_ctrl_pkg::txn_id_t        r_id_o,
    output icache_ctrl_pkg::word_t          r_rdata_o,

    // Per-core cache control
    output icache_ctrl_pkg::core_vec_t      bypass_req_o,
    input  wire icache_ctrl_pkg::core_vec_t bypass_ack_i,
    output icache_ctrl_pkg::core_vec_t      flush_req_o,
    input  wire icache_ctrl_pkg::core_vec_t flush_ack_i,
    output icache_ctrl_pkg::core_vec_t      clear_stat_o,
    output icache_ctrl_pkg::core_vec_t      enable_stat_o,

    // Per-core statistics counters
    input  wire icache_ctrl_pkg::word_t     hit_count_i   [icache_ctrl_pkg::NB_CORES],
    input  wire icache_ctrl_pkg::word_t     trans_count_i [icache_ctrl_pkg::NB_CORES],
    input  wire icache_ctrl_pkg::word_t     miss_count_i  [icache_ctrl_pkg::NB_CORES]
);

    cfg_access_if cfg_if ();
    ack_track_if  ack_if ();

    icache_ctrl_fsm fsm_i (
        .clk_i     (clk_i),
        .rst_ni    (rst_ni),
        .req_i     (req_i),
        .addr_i    (addr_i),
        .wen_i     (wen_i),
        .wdata_i   (wdata_i),
        .id_i      (id_i),
        .gnt_o     (gnt_o),
        .r_valid_o (r_valid_o),
        .r_id_o    (r_id_o),
        .cfg       (cfg_if.fsm),
        .ack       (ack_if.fsm)
    );

    icache_ctrl_regs regs_i (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .cfg           (cfg_if.regs),
        .hit_count_i   (hit_count_i),
        .trans_count_i (trans_count_i),
        .miss_count_i  (miss_count_i),
        .bypass_req_o  (bypass_req_o),
        .flush_req_o   (flush_req_o),
        .clear_stat_o  (clear_stat_o),
        .enable_stat_o (enable_stat_o),
        .r_rdata_o     (r_rdata_o)
    );

    // The tracker watches the request outputs against the core acknowledges
    icache_ack_tracker tracker_i (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .bypass_req_i (bypass_req_o),
        .bypass_ack_i (bypass_ack_i),
        .flush_req_i  (flush_req_o),
        .flush_ack_i  (flush_ack_i),
        .ack          (ack_if.tracker)
    );

endmodule

`default_nettype wire

/* tests/icache_core_model.sv */
////////////////////////////////////////////////////////////////////////////
// Model of the per-core instruction caches
// Answers bypass and flush requests after random delays, supplies counters
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module icache_core_model (
    input  wire logic                       clk_i,
    input  wire logic                       rst_ni,
    input  wire icache_ctrl_pkg::core_vec_t bypass_req_i,
    output icache_ctrl_pkg::core_vec_t      bypass_ack_o,
    input  wire icache_ctrl_pkg::core_vec_t flush_req_i,
    output icache_ctrl_pkg::core_vec_t      flush_ack_o,
    output icache_ctrl_pkg::word_t          hit_count_o   [icache_ctrl_pkg::NB_CORES],
    output icache_ctrl_pkg::word_t          trans_count_o [icache_ctrl_pkg::NB_CORES],
    output icache_ctrl_pkg::word_t          miss_count_o  [icache_ctrl_pkg::NB_CORES]
);

    import icache_ctrl_pkg::*;

    integer    seed = 32'hec1b;
    core_vec_t last_bypass;
    core_vec_t last_flush;
    core_vec_t flush_pending;
    int        bypass_delay [NB_CORES];
    int        flush_delay  [NB_CORES];

    // Caches come out of reset bypassed, counters stay fixed
    initial
    begin
        bypass_ack_o  = '1;
        flush_ack_o   = '0;
        last_bypass   = '1;
        last_flush    = '0;
        flush_pending = '0;
        for (int c = 0; c < NB_CORES; c++)
        begin
            hit_count_o[c]   = $random(seed);
            trans_count_o[c] = $random(seed);
            miss_count_o[c]  = $random(seed);
            bypass_delay[c]  = 0;
            flush_delay[c]   = 0;
        end
    end

    // Driven 1 ns after the edge, like the bus inputs
    always @(posedge clk_i)
    begin
        #1;
        if (rst_ni)
        begin
            for (int c = 0; c < NB_CORES; c++)
            begin
                if (bypass_req_i[c] != last_bypass[c])
                begin
                    bypass_delay[c] = $random(seed) & 7;
                end
                if (bypass_ack_o[c] != bypass_req_i[c])
                begin
                    if (bypass_delay[c] == 0)
                    begin
                        bypass_ack_o[c] = bypass_req_i[c];
                    end
                    else
                    begin
                        bypass_delay[c]--;
                    end
                end
                // Flush acknowledge is a single pulse per rising request
                flush_ack_o[c] = 1'b0;
                if (flush_req_i[c] && !last_flush[c])
                begin
                    flush_pending[c] = 1'b1;
                    flush_delay[c]   = $random(seed) & 7;
                end
                if (flush_pending[c])
                begin
                    if (flush_delay[c] == 0)
                    begin
                        flush_ack_o[c]   = 1'b1;
                        flush_pending[c] = 1'b0;
                    end
                    else
                    begin
                        flush_delay[c]--;
                    end
                end
            end
            last_bypass = bypass_req_i;
            last_flush  = flush_req_i;
        end
    end

endmodule

`default_nettype wire

/* tests/tb_icache_ctrl.sv */
////////////////////////////////////////////////////////////////////////////
// Testbench of the instruction cache control unit
// Bus reads and writes against a shadow register model
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module tb_icache_ctrl;

    import icache_ctrl_pkg::*;

    // About 60 bus operations of at most 20 cycles each, wide margin
    localparam int TIMEOUT_CYCLES = 20000;

    logic      clk;
    logic      rst_n;
    logic      req;
    reg_addr_t addr;
    logic      wen;
    word_t     wdata;
    txn_id_t   id;
    logic      gnt;
    logic      r_valid;
    txn_id_t   r_id;
    word_t     r_rdata;
    core_vec_t bypass_req;
    core_vec_t bypass_ack;
    core_vec_t flush_req;
    core_vec_t flush_ack;
    core_vec_t clear_stat;
    core_vec_t enable_stat;
    word_t     hit_cnt   [NB_CORES];
    word_t     trans_cnt [NB_CORES];
    word_t     miss_cnt  [NB_CORES];

    integer    seed = 32'hec1b;
    int        errors = 0;
    int        ops = 0;
    int        cycles = 0;
    txn_id_t   next_id = '0;

    // Shadow copy of the writable registers
    core_vec_t sh_enable = '0;
    core_vec_t sh_clear = '0;
    core_vec_t sh_enable_cnt = '0;

    icache_ctrl_top dut_i (
        .clk_i         (clk),
        .rst_ni        (rst_n),
        .req_i         (req),
        .addr_i        (addr),
        .wen_i         (wen),
        .wdata_i       (wdata),
        .id_i          (id),
        .gnt_o         (gnt),
        .r_valid_o     (r_valid),
        .r_id_o        (r_id),
        .r_rdata_o     (r_rdata),
        .bypass_req_o  (bypass_req),
        .bypass_ack_i  (bypass_ack),
        .flush_req_o   (flush_req),
        .flush_ack_i   (flush_ack),
        .clear_stat_o  (clear_stat),
        .enable_stat_o (enable_stat),
        .hit_count_i   (hit_cnt),
        .trans_count_i (trans_cnt),
        .miss_count_i  (miss_cnt)
    );

    icache_core_model cores_i (
        .clk_i         (clk),
        .rst_ni        (rst_n),
        .bypass_req_i  (bypass_req),
        .bypass_ack_o  (bypass_ack),
        .flush_req_i   (flush_req),
        .flush_ack_o   (flush_ack),
        .hit_count_o   (hit_cnt),
        .trans_count_o (trans_cnt),
        .miss_count_o  (miss_cnt)
    );

    initial
    begin
        clk = 1'b0;
    end

    always #4 clk = ~clk;

    always @(posedge clk)
    begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES)
        begin
            $display("Timeout: run did not end within %0d cycles", TIMEOUT_CYCLES);
            $display("Simulation failed");
            $finish;
        end
    end

    task automatic report_mismatch(input string name, input word_t got, input word_t exp);
        errors++;
        $display("[ERROR] %0t: %s = 0x%0h, expected 0x%0h", $time, name, got, exp);
    endtask

    task automatic report_failure(input string what);
        errors++;
        $display("[ERROR] %0t: %s", $time, what);
    endtask

    // Register value that a read of each offset must return
    function automatic word_t expected_read(input reg_addr_t a);
        longint unsigned hit_total;
        longint unsigned trans_total;
        longint unsigned miss_total;
        word_t           value;
        hit_total   = 0;
        trans_total = 0;
        miss_total  = 0;
        // Full totals first, the register keeps them modulo 2^32
        for (int c = 0; c < NB_CORES; c++)
        begin
            hit_total   = hit_total + hit_cnt[c];
            trans_total = trans_total + trans_cnt[c];
            miss_total  = miss_total + miss_cnt[c];
        end
        case (a)
            REG_ENABLE:     value = word_t'(sh_enable);
            // Flush mask is gone once its write has been answered
            REG_FLUSH:      value = '0;
            REG_RSVD:       value = RSVD_VALUE;
            REG_CLEAR_CNT:  value = word_t'(sh_clear);
            REG_ENABLE_CNT: value = word_t'(sh_enable_cnt);
            REG_HIT_SUM:    value = word_t'(hit_total % (64'd1 << DATA_W));
            REG_TRANS_SUM:  value = word_t'(trans_total % (64'd1 << DATA_W));
            REG_MISS_SUM:   value = word_t'(miss_total % (64'd1 << DATA_W));
            default:        value = UNMAPPED_VALUE;
        endcase
        return value;
    endfunction

    // Drives a request and returns just after the edge that accepts it
    task automatic issue_request(input reg_addr_t a, input logic is_read, input word_t d,
                                 input txn_id_t i);
        @(posedge clk);
        #1;
        req   = 1'b1;
        addr  = a;
        wen   = is_read;
        wdata = d;
        id    = i;
        do
            @(negedge clk);
        while (!gnt);
        @(posedge clk);
        #1;
        req = 1'b0;
    endtask

    task automatic bus_write(input reg_addr_t a, input word_t d);
        int        lat;
        int        clr_pulses;
        int        exp_pulses;
        core_vec_t mask;
        core_vec_t inv_mask;
        core_vec_t flush_seen;
        txn_id_t   id_v;
        mask       = d[NB_CORES-1:0];
        inv_mask   = ~mask;
        id_v       = next_id;
        next_id    = next_id + 1'b1;
        lat        = 0;
        clr_pulses = 0;
        flush_seen = '0;
        exp_pulses = (a == REG_CLEAR_CNT && mask != '0) ? 1 : 0;
        issue_request(a, 1'b0, d, id_v);
        do
        begin
            @(negedge clk);
            lat++;
            if (clear_stat != '0)
            begin
                clr_pulses++;
                if (clear_stat != mask)
                    report_mismatch("clear_stat_o", clear_stat, mask);
                if (r_valid)
                    report_failure("clear_stat_o pulsed in the response cycle");
            end
            if (!r_valid)
            begin
                if (gnt)
                    report_failure("gnt_o went high while a write was still pending");
                if (a == REG_ENABLE && bypass_req != inv_mask)
                    report_mismatch("bypass_req_o", bypass_req, inv_mask);
                if (a == REG_FLUSH && flush_req != mask)
                    report_mismatch("flush_req_o", flush_req, mask);
                flush_seen = flush_seen | (flush_ack & mask);
            end
        end
        while (!r_valid);
        ops++;
        if (r_id != id_v)
            report_mismatch("r_id_o", r_id, id_v);
        if (!gnt)
            report_failure("gnt_o did not return high with the write response");
        if (clr_pulses != exp_pulses)
            report_failure($sformatf("clear_stat_o pulsed %0d times instead of %0d",
                                     clr_pulses, exp_pulses));
        case (a)
            REG_ENABLE:
            begin
                if (bypass_req != inv_mask)
                    report_mismatch("bypass_req_o", bypass_req, inv_mask);
                if (bypass_ack != bypass_req)
                    report_mismatch("bypass_ack_i", bypass_ack, bypass_req);
            end
            REG_FLUSH:
            begin
                if (flush_seen != mask)
                    report_failure("flush answered before every flagged core acknowledged");
                if (flush_req != '0)
                    report_mismatch("flush_req_o", flush_req, '0);
            end
            REG_CLEAR_CNT,
            REG_ENABLE_CNT:
            begin
                if (lat != 2)
                    report_failure($sformatf("stat write answered after %0d cycles", lat));
            end
            default:
            begin
                if (lat != 1)
                    report_failure($sformatf("plain write answered after %0d cycles", lat));
            end
        endcase
    endtask

    task automatic bus_read(input reg_addr_t a, output word_t d);
        int      lat;
        txn_id_t id_v;
        id_v    = next_id;
        next_id = next_id + 1'b1;
        lat     = 0;
        // wen_i high selects a read
        issue_request(a, 1'b1, '0, id_v);
        do
        begin
            @(negedge clk);
            lat++;
        end
        while (!r_valid);
        ops++;
        if (r_id != id_v)
            report_mismatch("r_id_o", r_id, id_v);
        if (lat != 1)
            report_failure($sformatf("read answered after %0d cycles", lat));
        d = r_rdata;
    endtask

    task automatic check_read(input reg_addr_t a);
        word_t got;
        word_t exp;
        exp = expected_read(a);
        bus_read(a, got);
        if (got != exp)
            report_mismatch($sformatf("r_rdata_o at 0x%02h", a), got, exp);
    endtask

    initial
    begin
        core_vec_t mask;
        req   = 1'b0;
        addr  = '0;
        wen   = 1'b0;
        wdata = '0;
        id    = '0;
        rst_n = 1'b0;
        repeat (3) @(posedge clk);
        #1;
        rst_n = 1'b1;
        @(negedge clk);

        // State right after reset
        if (gnt !== 1'b1)
            report_mismatch("gnt_o", gnt, 1);
        if (r_valid !== 1'b0)
            report_mismatch("r_valid_o", r_valid, 0);
        if (bypass_req !== '1)
            report_mismatch("bypass_req_o", bypass_req, word_t'({NB_CORES{1'b1}}));
        if (flush_req !== '0)
            report_mismatch("flush_req_o", flush_req, 0);
        if (clear_stat !== '0)
            report_mismatch("clear_stat_o", clear_stat, 0);
        if (enable_stat !== '0)
            report_mismatch("enable_stat_o", enable_stat, 0);

        // Enable and bypass, the empty and the full mask first
        for (int n = 0; n < 10; n++)
        begin
            if (n == 0)
                mask = '0;
            else if (n == 1)
                mask = '1;
            else
                mask = core_vec_t'($random(seed));
            bus_write(REG_ENABLE, word_t'(mask));
            sh_enable = mask;
            check_read(REG_ENABLE);
        end

        for (int n = 0; n < 8; n++)
        begin
            mask = (n == 0) ? '1 : core_vec_t'($random(seed));
            bus_write(REG_FLUSH, word_t'(mask));
            check_read(REG_FLUSH);
        end

        // Statistics
        check_read(REG_HIT_SUM);
        check_read(REG_TRANS_SUM);
        check_read(REG_MISS_SUM);
        mask = core_vec_t'($random(seed)) | core_vec_t'(1);
        bus_write(REG_ENABLE_CNT, word_t'(mask));
        sh_enable_cnt = mask;
        if (enable_stat != mask)
            report_mismatch("enable_stat_o", enable_stat, mask);
        check_read(REG_ENABLE_CNT);
        for (int n = 0; n < 4; n++)
        begin
            mask = core_vec_t'($random(seed));
            if (mask == '0)
                mask = '1;
            bus_write(REG_CLEAR_CNT, word_t'(mask));
            sh_clear = mask;
            check_read(REG_CLEAR_CNT);
        end

        // Decode of reserved, unmapped and read-only offsets
        check_read(REG_RSVD);
        check_read(8'h20);
        check_read(8'h02);
        check_read(8'hFC);
        bus_write(8'h24, $random(seed));
        bus_write(REG_RSVD, $random(seed));
        bus_write(REG_HIT_SUM, $random(seed));
        check_read(REG_ENABLE);
        check_read(REG_HIT_SUM);

        $display("%0d bus operations, %0d errors", ops, errors);
        if (errors == 0)
            $display("Simulation completed successfully");
        else
            $display("Simulation failed");
        $finish;
    end

endmodule

`default_nettype wire

/* tb.f */
common/icache_ctrl_pkg.sv
common/cfg_access_if.sv
common/ack_track_if.sv
hw/icache_ctrl/icache_ack_tracker.sv
hw/icache_ctrl/icache_ctrl_fsm.sv
hw/icache_ctrl/icache_ctrl_regs.sv
hw/icache_ctrl/icache_ctrl_top.sv
tests/icache_core_model.sv
tests/tb_icache_ctrl.sv

/* run.sh */
#!/bin/sh
# Build the testbench with Verilator, run it and judge the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_icache_ctrl -f tb.f -o tb_icache_ctrl

./obj_dir/tb_icache_ctrl | tee sim.log

if grep -q "Simulation failed" sim.log; then
    echo "RESULT: FAIL"
    exit 1
fi
if ! grep -q "Simulation completed successfully" sim.log; then
    echo "RESULT: FAIL (run ended without a verdict)"
    exit 1
fi
echo "RESULT: PASS"
